//--- src/phold_pkg.sv
`default_nettype none

package phold_pkg;

   localparam int NUM_CORE      = 4;
   localparam int NUM_LP        = 16;
   localparam int LP_WID        = 4;
   localparam int TIME_WID      = 16;
   localparam int CORE_WID      = 2;
   localparam int Q_DEPTH       = 32;
   localparam int CNT_WID       = 6;
   localparam int MAX_DELAY_WID = 4;   // delay is 1 + this field
   localparam int NUM_PEER      = NUM_CORE + 1;   // cores plus the apb read path

   localparam int APB_AW     = 12;
   localparam int HIST_BASE  = 'h100;
   localparam int REG_CTRL   = 'h000;
   localparam int REG_END    = 'h004;
   localparam int REG_SEED   = 'h008;
   localparam int REG_STATUS = 'h00C;

   typedef logic [TIME_WID-1:0] sim_time_t;
   typedef logic [LP_WID-1:0]   lp_id_t;
   typedef logic [CORE_WID-1:0] core_id_t;
   typedef logic [CNT_WID-1:0]  q_count_t;
   typedef logic [31:0]         hist_word_t;   // count in 31:16, max time in 15:0

   typedef struct packed {
      lp_id_t    lp;
      sim_time_t ts;
   } event_t;

   typedef struct packed {
      logic              psel;
      logic              penable;
      logic              pwrite;
      logic [APB_AW-1:0] paddr;
      logic [31:0]       pwdata;
   } apb_req_t;

   typedef struct packed {
      logic        pready;
      logic [31:0] prdata;
      logic        pslverr;
   } apb_rsp_t;

   typedef struct packed {
      logic       req;
      logic       we;
      lp_id_t     lp;
      hist_word_t wdata;
   } hist_req_t;

   typedef enum logic [2:0] {IDLE, LOAD, RUN, DRAIN, DONE} run_state_t;

   typedef enum logic [2:0] {CS_IDLE, CS_RD, CS_RDATA, CS_WR, CS_OUT} core_state_t;

endpackage

`default_nettype wire

//--- src/event_queue.sv
`timescale 1ns/10ps
`default_nettype none

module event_queue (
   input  wire                 clk,
   input  wire                 rst_n,
   input  wire                 enq,
   input  wire                 deq,
   input  phold_pkg::event_t   in_event,
   output phold_pkg::event_t   head,
   output logic                empty,
   output logic                full,
   output phold_pkg::q_count_t count
);

   phold_pkg::event_t   mem    [phold_pkg::Q_DEPTH];   // kept sorted by time
   phold_pkg::event_t   after  [phold_pkg::Q_DEPTH];   // view after the removal
   phold_pkg::event_t   nxt    [phold_pkg::Q_DEPTH];
   phold_pkg::q_count_t cnt_d;
   phold_pkg::q_count_t pos;

   assign head  = mem[0];
   assign empty = count == '0;
   assign full  = count == phold_pkg::q_count_t'(phold_pkg::Q_DEPTH);

   always_comb begin
      cnt_d = count;
      for (int i = 0; i < phold_pkg::Q_DEPTH; i++) begin
         after[i] = mem[i];
         if (deq && i < phold_pkg::Q_DEPTH - 1) after[i] = mem[i + 1];
      end
      if (deq) cnt_d = count - 1'b1;
   end

   // equal times go behind the existing ones
   always_comb begin
      pos = '0;
      for (int i = 0; i < phold_pkg::Q_DEPTH; i++) begin
         if (i < int'(cnt_d) && after[i].ts <= in_event.ts) pos = phold_pkg::q_count_t'(i + 1);
      end
   end

   always_comb begin
      for (int i = 0; i < phold_pkg::Q_DEPTH; i++) begin
         if (!enq || i < int'(pos))
            nxt[i] = after[i];
         else if (i == int'(pos))
            nxt[i] = in_event;
         else
            nxt[i] = after[i - 1];   // shift later entries down
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < phold_pkg::Q_DEPTH; i++) mem[i] <= nxt[i];
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         count <= '0;
      else if (enq)
         count <= cnt_d + 1'b1;
      else
         count <= cnt_d;
   end

endmodule

`default_nettype wire

//--- src/lp_core.sv
`timescale 1ns/10ps
`default_nettype none

module lp_core #(
   parameter int CORE_IDX = 0
) (
   input  wire                   clk,
   input  wire                   rst_n,
   input  wire [31:0]            seed,
   input  wire                   start,
   input  phold_pkg::event_t     event_in,
   output logic                  idle,
   output phold_pkg::sim_time_t  cur_time,
   output logic                  new_vld,
   output phold_pkg::event_t     new_event,
   input  wire                   ack,
   output phold_pkg::hist_req_t  hist_req,
   input  wire                   hist_gnt,
   input  phold_pkg::hist_word_t hist_rdata
);

   phold_pkg::core_state_t state;
   phold_pkg::event_t      cur;
   phold_pkg::hist_word_t  wr_word;
   logic [31:0]            lfsr, seed_q, lfsr_next, seed_mix;
   phold_pkg::sim_time_t   max_ts;

   assign lfsr_next = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);   // galois taps
   assign seed_mix  = seed ^ 32'(CORE_IDX);
   assign max_ts    = hist_rdata[15:0] > cur.ts ? hist_rdata[15:0] : cur.ts;

   assign idle     = state == phold_pkg::CS_IDLE;
   assign new_vld  = state == phold_pkg::CS_OUT;
   assign cur_time = cur.ts;

   always_comb begin
      hist_req = '{req: 1'b0, we: 1'b0, lp: cur.lp, wdata: wr_word};
      if (state == phold_pkg::CS_RD) hist_req.req = 1'b1;
      if (state == phold_pkg::CS_WR) begin
         hist_req.req = 1'b1;
         hist_req.we  = 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state  <= phold_pkg::CS_IDLE;
         lfsr   <= 32'h1;
         seed_q <= '0;
      end else begin
         if (seed != seed_q) begin   // new run seed
            seed_q <= seed;
            lfsr   <= seed_mix == '0 ? 32'h1 : seed_mix;
         end else if (start && idle) begin
            lfsr <= lfsr_next;
         end
         case (state)
            phold_pkg::CS_IDLE:  if (start) state <= phold_pkg::CS_RD;
            phold_pkg::CS_RD:    if (hist_gnt) state <= phold_pkg::CS_RDATA;
            phold_pkg::CS_RDATA: state <= phold_pkg::CS_WR;
            phold_pkg::CS_WR:    if (hist_gnt) state <= phold_pkg::CS_OUT;
            phold_pkg::CS_OUT:   if (ack) state <= phold_pkg::CS_IDLE;
            default:             state <= phold_pkg::CS_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start && idle) begin
         cur          <= event_in;
         new_event.lp <= lfsr_next[phold_pkg::LP_WID-1:0];   // random target
         new_event.ts <= event_in.ts + phold_pkg::sim_time_t'(1)
                         + phold_pkg::sim_time_t'(lfsr_next[8 +: phold_pkg::MAX_DELAY_WID]);
      end
      if (state == phold_pkg::CS_RDATA) wr_word <= {hist_rdata[31:16] + 16'd1, max_ts};
   end

endmodule

`default_nettype wire

//--- src/hist_store.sv
`timescale 1ns/10ps
`default_nettype none

module hist_store (
   input  wire                            clk,
   input  wire                            rst_n,
   input  phold_pkg::hist_req_t           req [phold_pkg::NUM_PEER],
   output logic [phold_pkg::NUM_PEER-1:0] gnt,
   output phold_pkg::hist_word_t          rdata
);

   localparam int PW = $clog2(phold_pkg::NUM_PEER);

   phold_pkg::hist_word_t mem [phold_pkg::NUM_LP];
   logic [PW-1:0] ptr;        // first peer to look at
   logic [PW-1:0] sel;
   logic          found;
   logic          lock;       // a core holds the table between its read and write
   logic [PW-1:0] lock_id;

   always_comb begin
      int idx;
      sel   = '0;
      found = 1'b0;
      for (int k = phold_pkg::NUM_PEER - 1; k >= 0; k--) begin
         idx = (int'(ptr) + k) % phold_pkg::NUM_PEER;
         if (req[idx].req && (!lock || idx == int'(lock_id))) begin
            sel   = PW'(idx);
            found = 1'b1;
         end
      end
   end

   assign gnt = found ? phold_pkg::NUM_PEER'(1) << sel : '0;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr     <= '0;
         lock    <= 1'b0;
         lock_id <= '0;
         for (int i = 0; i < phold_pkg::NUM_LP; i++) mem[i] <= '0;
      end else if (found) begin
         ptr <= sel == PW'(phold_pkg::NUM_PEER - 1) ? '0 : sel + 1'b1;
         if (req[sel].we) begin
            mem[req[sel].lp] <= req[sel].wdata;
            if (lock && sel == lock_id) lock <= 1'b0;
         end else if (int'(sel) < phold_pkg::NUM_CORE) begin
            lock    <= 1'b1;   // core read starts a read-modify-write
            lock_id <= sel;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (found && !req[sel].we) rdata <= mem[req[sel].lp];
   end

endmodule

`default_nettype wire

//--- src/engine_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module engine_ctrl (
   input  wire                            clk,
   input  wire                            rst_n,
   input  phold_pkg::apb_req_t            apb_req,
   output phold_pkg::apb_rsp_t            apb_rsp,
   output logic                           q_enq,
   output logic                           q_deq,
   output phold_pkg::event_t              q_in,
   input  phold_pkg::event_t              q_head,
   input  wire                            q_empty,
   input  wire                            q_full,
   input  phold_pkg::q_count_t            q_count,
   input  wire [phold_pkg::NUM_CORE-1:0]  core_idle,
   input  phold_pkg::sim_time_t           core_time [phold_pkg::NUM_CORE],
   output logic [phold_pkg::NUM_CORE-1:0] start,
   output phold_pkg::event_t              disp_event,
   input  wire [phold_pkg::NUM_CORE-1:0]  new_vld,
   input  phold_pkg::event_t              new_event [phold_pkg::NUM_CORE],
   output logic [phold_pkg::NUM_CORE-1:0] ack,
   output logic [31:0]                    seed,
   output phold_pkg::hist_req_t           hist_apb_req,
   input  wire                            hist_apb_gnt,
   input  phold_pkg::hist_word_t          hist_rdata,
   output phold_pkg::core_id_t            sched_core,
   output phold_pkg::sim_time_t           gvt,
   output logic                           done
);

   phold_pkg::run_state_t state;
   phold_pkg::lp_id_t     load_cnt;
   phold_pkg::sim_time_t  end_reg;
   logic [31:0]           seed_reg;
   phold_pkg::core_id_t   ack_ptr, ack_sel, disp_sel;
   logic                  ack_found, idle_found, ack_ok, disp_ok;
   logic                  h_req, h_wait, h_rdy;   // apb history read progress
   phold_pkg::hist_word_t h_data;
   phold_pkg::sim_time_t  gmin;
   logic                  gval;

   wire        access  = apb_req.psel & apb_req.penable;
   wire [11:0] a       = apb_req.paddr;
   wire is_ctrl = a == phold_pkg::REG_CTRL;
   wire is_end  = a == phold_pkg::REG_END;
   wire is_seed = a == phold_pkg::REG_SEED;
   wire is_stat = a == phold_pkg::REG_STATUS;
   wire hist_hit = a >= phold_pkg::HIST_BASE && a < phold_pkg::HIST_BASE + 4 * phold_pkg::NUM_LP;
   wire reg_hit  = is_ctrl | is_end | is_seed | is_stat;
   wire hist_rd  = access & hist_hit & ~apb_req.pwrite;
   wire start_run = access & apb_req.pwrite & is_ctrl & apb_req.pwdata[0]
                    & (state == phold_pkg::IDLE || state == phold_pkg::DONE);

   always_comb begin
      apb_rsp.pready  = access & (~(hist_hit & ~apb_req.pwrite) | h_rdy);
      apb_rsp.pslverr = access & ((hist_hit & apb_req.pwrite) | ~(reg_hit | hist_hit));
      apb_rsp.prdata  = '0;
      if (is_end)  apb_rsp.prdata = 32'(end_reg);
      if (is_seed) apb_rsp.prdata = seed_reg;
      if (is_stat) apb_rsp.prdata = {gvt, 2'b00, q_count, 7'b0, done};
      if (hist_hit) apb_rsp.prdata = h_data;
   end

   // round-robin pick among pending new events, lowest idle core for dispatch
   always_comb begin
      int idx;
      ack_sel    = '0;
      ack_found  = 1'b0;
      disp_sel   = '0;
      idle_found = 1'b0;
      for (int k = phold_pkg::NUM_CORE - 1; k >= 0; k--) begin
         idx = (int'(ack_ptr) + k) % phold_pkg::NUM_CORE;
         if (new_vld[idx]) begin
            ack_sel   = phold_pkg::core_id_t'(idx);
            ack_found = 1'b1;
         end
         if (core_idle[k]) begin
            disp_sel   = phold_pkg::core_id_t'(k);
            idle_found = 1'b1;
         end
      end
   end

   assign ack_ok  = ack_found & ~q_full & (state == phold_pkg::RUN || state == phold_pkg::DRAIN);
   assign disp_ok = state == phold_pkg::RUN && !q_empty && idle_found && !ack_ok
                    && q_head.ts <= end_reg;   // new events win over dispatch
   assign ack     = ack_ok ? phold_pkg::NUM_CORE'(1) << ack_sel : '0;
   assign start   = disp_ok ? phold_pkg::NUM_CORE'(1) << disp_sel : '0;
   assign q_deq   = disp_ok;
   assign q_enq   = state == phold_pkg::LOAD || ack_ok;
   assign q_in    = state == phold_pkg::LOAD ? phold_pkg::event_t'{lp: load_cnt, ts: '0}
                                             : new_event[ack_sel];
   assign disp_event = q_head;
   assign sched_core = disp_sel;
   assign done       = state == phold_pkg::DONE;

   // LOAD also clears the history table through the apb slot
   always_comb begin
      if (state == phold_pkg::LOAD)
         hist_apb_req = '{req: 1'b1, we: 1'b1, lp: load_cnt, wdata: '0};
      else
         hist_apb_req = '{req: h_req, we: 1'b0, lp: a[2 +: phold_pkg::LP_WID], wdata: '0};
   end

   always_comb begin
      gmin = q_head.ts;
      gval = !q_empty;
      for (int i = 0; i < phold_pkg::NUM_CORE; i++) begin
         if (!core_idle[i] && (!gval || core_time[i] < gmin)) begin
            gmin = core_time[i];
            gval = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= phold_pkg::IDLE;
         load_cnt <= '0;
         end_reg  <= '0;
         seed_reg <= '0;
         seed     <= '0;
         ack_ptr  <= '0;
         gvt      <= '0;
         h_req    <= 1'b0;
         h_wait   <= 1'b0;
         h_rdy    <= 1'b0;
      end else begin
         if (access && apb_req.pwrite && is_end) end_reg <= apb_req.pwdata[15:0];
         if (access && apb_req.pwrite && is_seed) seed_reg <= apb_req.pwdata;
         if (ack_ok) ack_ptr <= ack_sel + 1'b1;
         if ((state == phold_pkg::RUN || state == phold_pkg::DRAIN) && gval) gvt <= gmin;
         if (hist_rd && !h_req && !h_wait && !h_rdy && state != phold_pkg::LOAD) h_req <= 1'b1;
         if (h_req && hist_apb_gnt && state != phold_pkg::LOAD) begin
            h_req  <= 1'b0;
            h_wait <= 1'b1;
         end
         if (h_wait) begin
            h_wait <= 1'b0;
            h_rdy  <= 1'b1;   // data lands in h_data this edge
         end
         if (h_rdy && access) h_rdy <= 1'b0;
         case (state)
            phold_pkg::IDLE, phold_pkg::DONE: if (start_run) begin
               state    <= phold_pkg::LOAD;
               load_cnt <= '0;
               gvt      <= '0;
               seed     <= seed_reg;
            end
            phold_pkg::LOAD: begin
               load_cnt <= load_cnt + 1'b1;
               if (load_cnt == phold_pkg::lp_id_t'(phold_pkg::NUM_LP - 1)) state <= phold_pkg::RUN;
            end
            phold_pkg::RUN: if (!q_empty && q_head.ts > end_reg) state <= phold_pkg::DRAIN;
            phold_pkg::DRAIN: if (&core_idle) state <= phold_pkg::DONE;
            default: state <= phold_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (h_wait) h_data <= hist_rdata;
   end

endmodule

`default_nettype wire

//--- src/phold_engine.sv
`timescale 1ns/10ps
`default_nettype none

module phold_engine (
   input  wire                  clk,
   input  wire                  rst_n,
   input  phold_pkg::apb_req_t  apb_req,
   output phold_pkg::apb_rsp_t  apb_rsp,
   output logic                 sched_vld,
   output phold_pkg::event_t    sched_event,
   output phold_pkg::core_id_t  sched_core,
   output phold_pkg::sim_time_t gvt,
   output logic                 done
);

   logic                 q_enq, q_deq, q_empty, q_full;
   phold_pkg::event_t    q_in, q_head;
   phold_pkg::q_count_t  q_count;

   logic [phold_pkg::NUM_CORE-1:0] core_idle, start, new_vld, ack;
   phold_pkg::sim_time_t core_time [phold_pkg::NUM_CORE];
   phold_pkg::event_t    new_event [phold_pkg::NUM_CORE];
   phold_pkg::event_t    disp_event;
   logic [31:0]          seed;

   phold_pkg::hist_req_t hreq [phold_pkg::NUM_PEER];   // last slot is the apb path
   logic [phold_pkg::NUM_PEER-1:0] hgnt;
   phold_pkg::hist_word_t hist_rdata;

   assign sched_vld   = |start;   // one dispatch pulse per cycle at most
   assign sched_event = disp_event;

   engine_ctrl u_ctrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .apb_req      (apb_req),
      .apb_rsp      (apb_rsp),
      .q_enq        (q_enq),
      .q_deq        (q_deq),
      .q_in         (q_in),
      .q_head       (q_head),
      .q_empty      (q_empty),
      .q_full       (q_full),
      .q_count      (q_count),
      .core_idle    (core_idle),
      .core_time    (core_time),
      .start        (start),
      .disp_event   (disp_event),
      .new_vld      (new_vld),
      .new_event    (new_event),
      .ack          (ack),
      .seed         (seed),
      .hist_apb_req (hreq[phold_pkg::NUM_CORE]),
      .hist_apb_gnt (hgnt[phold_pkg::NUM_CORE]),
      .hist_rdata   (hist_rdata),
      .sched_core   (sched_core),
      .gvt          (gvt),
      .done         (done)
   );

   event_queue u_queue (
      .clk      (clk),
      .rst_n    (rst_n),
      .enq      (q_enq),
      .deq      (q_deq),
      .in_event (q_in),
      .head     (q_head),
      .empty    (q_empty),
      .full     (q_full),
      .count    (q_count)
   );

   for (genvar g = 0; g < phold_pkg::NUM_CORE; g++) begin : gen_core
      lp_core #(.CORE_IDX(g)) u_core (
         .clk        (clk),
         .rst_n      (rst_n),
         .seed       (seed),
         .start      (start[g]),
         .event_in   (disp_event),
         .idle       (core_idle[g]),
         .cur_time   (core_time[g]),
         .new_vld    (new_vld[g]),
         .new_event  (new_event[g]),
         .ack        (ack[g]),
         .hist_req   (hreq[g]),
         .hist_gnt   (hgnt[g]),
         .hist_rdata (hist_rdata)
      );
   end

   hist_store u_hist (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (hreq),
      .gnt   (hgnt),
      .rdata (hist_rdata)
   );

endmodule

`default_nettype wire

//--- test/tb_apb_tasks.svh
// one apb transfer, setup phase then access phase until pready
task automatic apb_transfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
   @(posedge clk);
   apb_req.psel    <= 1'b1;
   apb_req.penable <= 1'b0;
   apb_req.pwrite  <= wr;
   apb_req.paddr   <= addr;
   apb_req.pwdata  <= wdata;
   @(posedge clk);
   apb_req.penable <= 1'b1;   // access phase
   @(negedge clk);
   while (!apb_rsp.pready) @(negedge clk);   // history reads stretch this
   rdata = apb_rsp.prdata;
   err   = apb_rsp.pslverr;
   @(posedge clk);
   apb_req.psel    <= 1'b0;
   apb_req.penable <= 1'b0;
endtask

task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
   logic [31:0] unused_rd;
   apb_transfer(1'b1, addr, data, unused_rd, err);
endtask

task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
   apb_transfer(1'b0, addr, 32'h0, data, err);
endtask

// compare and stop at the first mismatch
task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
   if (got !== exp) begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
   end
endtask

//--- test/tb_phold_engine.sv
`timescale 1ns/10ps
`default_nettype none

module tb_phold_engine;

   localparam int MAX_TESTS = 64;

   logic                 clk;
   logic                 rst_n;
   phold_pkg::apb_req_t  apb_req;
   phold_pkg::apb_rsp_t  apb_rsp;
   logic                 sched_vld;
   phold_pkg::event_t    sched_event;
   phold_pkg::core_id_t  sched_core;
   phold_pkg::sim_time_t gvt;
   logic                 done;

   // test table
   logic [31:0]          t_seed  [MAX_TESTS];
   phold_pkg::sim_time_t t_end   [MAX_TESTS];
   logic [31:0]          t_count [MAX_TESTS];
   int                   num_tests = 0;
   int                   watchdog_cycles = 0;

   // what the monitor saw in the current run
   logic                         mon_en;
   phold_pkg::sim_time_t         cur_end;
   int                           sched_total;
   logic [phold_pkg::NUM_LP-1:0] load_seen;
   int                           lp_hits [phold_pkg::NUM_LP];
   phold_pkg::sim_time_t         lp_max  [phold_pkg::NUM_LP];
   phold_pkg::sim_time_t         last_gvt;
   int                           mon_cycle;
   int                           core_last [phold_pkg::NUM_CORE];   // cycle of the last start

   `include "tb_apb_tasks.svh"

   phold_engine DUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .apb_req     (apb_req),
      .apb_rsp     (apb_rsp),
      .sched_vld   (sched_vld),
      .sched_event (sched_event),
      .sched_core  (sched_core),
      .gvt         (gvt),
      .done        (done)
   );

   always begin
      clk = 1'b0;
      #4;
      clk = 1'b1;
      #4;
   end

   // sched and gvt sampled mid-cycle
   always @(negedge clk) begin
      int gap;
      if (mon_en) begin
         mon_cycle++;
         check_value("gvt", 32'(gvt), 32'(gvt < last_gvt ? last_gvt : gvt));   // no step back
         last_gvt = gvt;
         if (sched_vld) begin
            check_value("sched_event.ts", 32'(sched_event.ts),
                        32'(sched_event.ts < gvt ? gvt : sched_event.ts));
            check_value("sched_event.ts", 32'(sched_event.ts),
                        32'(sched_event.ts > cur_end ? cur_end : sched_event.ts));
            if (sched_total < phold_pkg::NUM_CORE)   // all cores idle, lowest index first
               check_value("sched_core", 32'(sched_core), 32'(sched_total));
            // 4 cycles to new_vld, idle again only after the ack
            gap = mon_cycle - core_last[sched_core];
            check_value("sched_core restart gap", 32'(gap), 32'(gap < 5 ? 5 : gap));
            core_last[sched_core] = mon_cycle;
            if (sched_total < phold_pkg::NUM_LP) begin
               check_value("sched_event.ts", 32'(sched_event.ts), 32'h0);   // still time-0 events
               check_value("load_seen[sched_event.lp]", 32'(load_seen[sched_event.lp]), 32'h0);
               load_seen[sched_event.lp] = 1'b1;
            end
            lp_hits[sched_event.lp]++;
            if (sched_event.ts > lp_max[sched_event.lp]) lp_max[sched_event.lp] = sched_event.ts;
            sched_total++;
         end
      end
   end

   task automatic load_tests();
      int          fd;
      int          n;
      string       line;
      logic [31:0] s, e, c;
      fd = $fopen("test/phold_tests.txt", "r");
      if (fd == 0) begin
         $display("Could not open the data file test/phold_tests.txt");
         $display("Test failed");
         $fatal(1, "no data file");
      end else begin
         while (!$feof(fd) && num_tests < MAX_TESTS) begin
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%h %h %h", s, e, c) == 3) begin   // comments fail here
               t_seed[num_tests]  = s;
               t_end[num_tests]   = e[15:0];
               t_count[num_tests] = c;
               num_tests++;
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic reset_dut();
      @(posedge clk);
      rst_n   <= 1'b0;
      apb_req <= '0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
   endtask

   task automatic run_test(input int idx);
      logic [31:0] rd;
      logic        err;
      int          sum;
      logic [31:0] gvt_rd;
      logic [31:0] gvt_hi;
      mon_en      = 1'b0;
      cur_end     = t_end[idx];
      sched_total = 0;
      load_seen   = '0;
      last_gvt    = '0;
      mon_cycle   = 0;
      for (int i = 0; i < phold_pkg::NUM_LP; i++) begin
         lp_hits[i] = 0;
         lp_max[i]  = '0;
      end
      for (int i = 0; i < phold_pkg::NUM_CORE; i++) core_last[i] = -1000;
      $display("test %0d: seed 0x%h, end time 0x%h", idx, t_seed[idx], t_end[idx]);
      reset_dut();

      // register file
      apb_write(12'(phold_pkg::REG_END), 32'(t_end[idx]), err);
      check_value("apb_rsp.pslverr", 32'(err), 32'h0);
      apb_read(12'(phold_pkg::REG_END), rd, err);
      check_value("apb_rsp.prdata", rd, 32'(t_end[idx]));
      apb_write(12'(phold_pkg::REG_SEED), t_seed[idx], err);
      check_value("apb_rsp.pslverr", 32'(err), 32'h0);
      apb_read(12'(phold_pkg::REG_SEED), rd, err);
      check_value("apb_rsp.prdata", rd, t_seed[idx]);
      apb_write(12'(phold_pkg::HIST_BASE), 32'h5a5a_0001, err);   // history is read-only
      check_value("apb_rsp.pslverr", 32'(err), 32'h1);

      mon_en = 1'b1;
      apb_write(12'(phold_pkg::REG_CTRL), 32'h1, err);
      while (!done) @(negedge clk);
      mon_en = 1'b0;
      check_value("load_seen", 32'(load_seen), 32'({phold_pkg::NUM_LP{1'b1}}));

      apb_read(12'(phold_pkg::REG_STATUS), rd, err);
      check_value("status.done", 32'(rd[0]), 32'h1);
      check_value("status.count", 32'(rd[13:8]), t_count[idx]);
      // leftover events are successors, 1 to 16 past a time no later than the end time
      gvt_rd = 32'(rd[31:16]);
      gvt_hi = 32'(cur_end) + (32'd1 << phold_pkg::MAX_DELAY_WID);
      check_value("status.gvt", gvt_rd, gvt_rd < 32'd1 ? 32'd1 : gvt_rd);
      check_value("status.gvt", gvt_rd, gvt_rd > gvt_hi ? gvt_hi : gvt_rd);

      sum = 0;
      for (int n = 0; n < phold_pkg::NUM_LP; n++) begin
         apb_read(12'(phold_pkg::HIST_BASE + 4 * n), rd, err);
         check_value($sformatf("hist[%0d] pslverr", n), 32'(err), 32'h0);
         check_value($sformatf("hist[%0d].count", n), 32'(rd[31:16]), 32'(lp_hits[n]));
         check_value($sformatf("hist[%0d].time", n), 32'(rd[15:0]), 32'(lp_max[n]));
         sum += int'(rd[31:16]);
      end
      check_value("history count sum", 32'(sum), 32'(sched_total));
   endtask

   initial begin
      int max_end;
      rst_n   = 1'b0;
      apb_req = '0;
      mon_en  = 1'b0;
      load_tests();
      if (num_tests == 0) begin
         $display("The data file holds no test line");
         $display("Test failed");
         $fatal(1, "no tests");
      end else begin
         max_end = 0;
         for (int i = 0; i < num_tests; i++) begin
            if (int'(t_end[i]) > max_end) max_end = int'(t_end[i]);
         end
         watchdog_cycles = num_tests * (max_end + 64) * phold_pkg::NUM_LP * 40;
         for (int i = 0; i < num_tests; i++) run_test(i);
         $display("Test passed");
         $finish;
      end
   end

   // budget grows with the number of tests and the longest end time
   initial begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("Timeout: the engine did not finish all tests within %0d cycles", watchdog_cycles);
      $display("Test failed");
      $fatal(1, "watchdog");
   end

endmodule

`default_nettype wire

//--- phold_engine.f
+incdir+test
src/phold_pkg.sv
src/event_queue.sv
src/lp_core.sv
src/hist_store.sv
src/engine_ctrl.sv
src/phold_engine.sv
test/tb_phold_engine.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_phold_engine -f phold_engine.f

out=$(./obj_dir/Vtb_phold_engine 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
   exit 0
else
   exit 1
fi

//--- test/phold_tests.txt
# columns, all hex: seed, end time, expected final queue count
# the count stays at NUM_LP (0x10) since every event schedules exactly one successor
17ffa4ff 0040 10
0badf00d 0080 10
12345678 0020 10
deadbeef 00c8 10
00000001 0010 10
a5a5a5a5 0100 10
3c3c0f0f 0000 10
7e0019c3 0055 10
